// File: source/pix_consts.svh
`ifndef PIX_CONSTS_SVH
`define PIX_CONSTS_SVH

// Words held by one storage block
`define PIX_IMAGE_SIZE 16

// Number of storage blocks
`define PIX_BLOCK_COUNT 8

// Offset inside a block, at least one bit wide
`define PIX_OFFSET_W ((`PIX_IMAGE_SIZE > 1) ? $clog2(`PIX_IMAGE_SIZE) : 1)

// Block index
`define PIX_BLOCK_W 3

`endif

// File: source/pix_types_pkg.sv
package pix_types_pkg;

    // Sensor side inputs, sampled on clk
    typedef struct packed {
        logic        valid;
        logic        fv;
        logic        lv;
        logic [11:0] data;
    } pix_bus_t;

    // One stored word, 12-bit pixel with zero fill on top
    typedef struct packed {
        logic [3:0]  pad;
        logic [11:0] pixel;
    } pix_word_t;

endpackage

// File: source/ctrl_types_pkg.sv
`include "pix_consts.svh"

package ctrl_types_pkg;

    typedef enum logic {
        OP_CAPTURE = 1'b0,
        OP_READOUT = 1'b1
    } ctrl_op_e;

    // Command word held by the host while cmd_req is high
    typedef struct packed {
        ctrl_op_e                op;
        logic [`PIX_BLOCK_W-1:0] block;
    } ctrl_cmd_t;

    // Single access to the frame store
    typedef struct packed {
        logic                     we;
        logic                     re;
        logic [`PIX_BLOCK_W-1:0]  block;
        logic [`PIX_OFFSET_W-1:0] offset;
        pix_types_pkg::pix_word_t wdata;
    } store_req_t;

endpackage

// File: source/pix_ctrl_fsm.sv
`timescale 1ns/1ps
`include "pix_consts.svh"

module pix_ctrl_fsm (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cmd_req,
    input  ctrl_types_pkg::ctrl_cmd_t  cmd,
    output logic                       cmd_ack,
    output logic                       gate_arm,
    input  logic                       gate_valid,
    input  pix_types_pkg::pix_word_t   gate_word,
    output ctrl_types_pkg::store_req_t store_req,
    output logic                       cnt_step,
    output logic                       cnt_clear,
    input  logic [`PIX_OFFSET_W-1:0]   offset,
    input  logic                       last,
    output logic                       rd_enable,
    input  logic                       read_strobe,
    input  logic                       word_done
);
    import ctrl_types_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CAPTURE,
        ST_READOUT,
        ST_ACK,
        ST_WAIT_REL
    } state_e;

    state_e                  state;
    logic [`PIX_BLOCK_W-1:0] block_q;
    logic                    capture_write;
    logic                    readout_step;

    assign capture_write = (state == ST_CAPTURE) && gate_valid;
    assign readout_step  = (state == ST_READOUT) && word_done;

    // ============================================================
    // Command sequencing
    // ============================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_req) begin
                        state <= (cmd.op == OP_CAPTURE) ? ST_CAPTURE : ST_READOUT;
                    end
                end
                // The write of the final word closes the capture
                ST_CAPTURE: begin
                    if (capture_write && last) begin
                        state <= ST_ACK;
                    end
                end
                ST_READOUT: begin
                    if (readout_step && last) begin
                        state <= ST_ACK;
                    end
                end
                // Hold the acknowledge until the host releases its request
                ST_ACK: begin
                    if (!cmd_req) begin
                        state <= ST_WAIT_REL;
                    end
                end
                // One cycle with both req and ack low before a new command
                ST_WAIT_REL: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Target block is captured when the command is taken
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cmd_req) begin
            block_q <= cmd.block;
        end
    end

    // ============================================================
    // Outputs
    // ============================================================

    assign cmd_ack   = (state == ST_ACK);
    assign gate_arm  = (state == ST_CAPTURE);
    assign rd_enable = (state == ST_READOUT);
    assign cnt_clear = (state == ST_IDLE);
    assign cnt_step  = capture_write || readout_step;

    always_comb begin
        store_req.we     = capture_write;
        store_req.re     = rd_enable && read_strobe;
        store_req.block  = block_q;
        store_req.offset = offset;
        store_req.wdata  = gate_word;
    end

endmodule

// File: source/word_counter.sv
`timescale 1ns/1ps
`include "pix_consts.svh"

module word_counter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     step,
    input  logic                     clear,
    output logic [`PIX_OFFSET_W-1:0] offset,
    output logic                     last
);

    // Final word of the block
    assign last = (int'(offset) == `PIX_IMAGE_SIZE - 1);

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            offset <= '0;
        end else if (step) begin
            // Wrap after the final word so a stray step stays in range
            if (last) begin
                offset <= '0;
            end else begin
                offset <= offset + 1'b1;
            end
        end
    end

endmodule

// File: source/frame_gate.sv
`timescale 1ns/1ps

module frame_gate (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     arm,
    input  pix_types_pkg::pix_bus_t  pix,
    output logic                     word_valid,
    output pix_types_pkg::pix_word_t word
);

    // Set once fv has been low while armed
    logic fv_low_seen;
    logic accept;

    // fv high after a low sample marks the start of a frame
    assign accept = fv_low_seen && pix.valid && pix.fv && pix.lv;

    always_ff @(posedge clk) begin
        if (!rst_n || !arm) begin
            fv_low_seen <= 1'b0;
            word_valid  <= 1'b0;
        end else begin
            if (!pix.fv) begin
                fv_low_seen <= 1'b1;
            end
            word_valid <= accept;
        end
    end

    // Widen the pixel with four zero bits
    always_ff @(posedge clk) begin
        if (accept) begin
            word.pad   <= '0;
            word.pixel <= pix.data;
        end
    end

endmodule

// File: source/frame_store.sv
`timescale 1ns/1ps
`include "pix_consts.svh"

module frame_store (
    input  logic                       clk,
    input  ctrl_types_pkg::store_req_t req,
    output pix_types_pkg::pix_word_t   rdata
);
    import pix_types_pkg::*;

    pix_word_t mem [`PIX_BLOCK_COUNT * `PIX_IMAGE_SIZE];
    int        addr;

    // Blocks sit back to back, IMAGE_SIZE words each
    assign addr = int'(req.block) * `PIX_IMAGE_SIZE + int'(req.offset);

    always_ff @(posedge clk) begin
        if (req.we) begin
            mem[addr] <= req.wdata;
        end
    end

    // Registered read port, data valid the cycle after re
    always_ff @(posedge clk) begin
        if (req.re) begin
            rdata <= mem[addr];
        end
    end

endmodule

// File: source/readout_port.sv
`timescale 1ns/1ps

module readout_port (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     enable,
    input  logic                     rd_req,
    output logic                     rd_ack,
    output pix_types_pkg::pix_word_t rd_data,
    output logic                     read_strobe,
    input  pix_types_pkg::pix_word_t rdata,
    output logic                     word_done
);

    // Store read issued last cycle
    logic fetch_q;

    // New request only once the previous word has fully retired,
    // so the offset has already stepped when the read is issued
    assign read_strobe = enable && rd_req && !fetch_q && !rd_ack && !word_done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_q   <= 1'b0;
            rd_ack    <= 1'b0;
            word_done <= 1'b0;
        end else begin
            fetch_q   <= read_strobe;
            word_done <= rd_ack && !rd_req;
            if (fetch_q) begin
                rd_ack <= 1'b1;
            end else if (!rd_req) begin
                rd_ack <= 1'b0;
            end
        end
    end

    // Store output is held for the host until the next word
    always_ff @(posedge clk) begin
        if (fetch_q) begin
            rd_data <= rdata;
        end
    end

endmodule

// File: source/pix_capture_top.sv
`timescale 1ns/1ps
`include "pix_consts.svh"

module pix_capture_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cmd_req,
    input  ctrl_types_pkg::ctrl_cmd_t cmd,
    output logic                      cmd_ack,
    input  pix_types_pkg::pix_bus_t   pix,
    input  logic                      rd_req,
    output logic                      rd_ack,
    output pix_types_pkg::pix_word_t  rd_data
);
    import pix_types_pkg::*;
    import ctrl_types_pkg::*;

    logic                     gate_arm;
    logic                     gate_valid;
    pix_word_t                gate_word;
    store_req_t               store_req;
    pix_word_t                store_rdata;
    logic                     cnt_step;
    logic                     cnt_clear;
    logic [`PIX_OFFSET_W-1:0] offset;
    logic                     last;
    logic                     rd_enable;
    logic                     read_strobe;
    logic                     word_done;

    // ============================================================
    // Control
    // ============================================================

    pix_ctrl_fsm u_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_req    (cmd_req),
        .cmd        (cmd),
        .cmd_ack    (cmd_ack),
        .gate_arm   (gate_arm),
        .gate_valid (gate_valid),
        .gate_word  (gate_word),
        .store_req  (store_req),
        .cnt_step   (cnt_step),
        .cnt_clear  (cnt_clear),
        .offset     (offset),
        .last       (last),
        .rd_enable  (rd_enable),
        .read_strobe(read_strobe),
        .word_done  (word_done)
    );

    word_counter u_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .step  (cnt_step),
        .clear (cnt_clear),
        .offset(offset),
        .last  (last)
    );

    // ============================================================
    // Data path
    // ============================================================

    frame_gate u_gate (
        .clk       (clk),
        .rst_n     (rst_n),
        .arm       (gate_arm),
        .pix       (pix),
        .word_valid(gate_valid),
        .word      (gate_word)
    );

    frame_store u_store (
        .clk  (clk),
        .req  (store_req),
        .rdata(store_rdata)
    );

    readout_port u_readout (
        .clk        (clk),
        .rst_n      (rst_n),
        .enable     (rd_enable),
        .rd_req     (rd_req),
        .rd_ack     (rd_ack),
        .rd_data    (rd_data),
        .read_strobe(read_strobe),
        .rdata      (store_rdata),
        .word_done  (word_done)
    );

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held low across the first two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// File: tb/tb_pix_capture.sv
`timescale 1ns/1ps
`include "pix_consts.svh"

module tb_pix_capture;
    import pix_types_pkg::*;
    import ctrl_types_pkg::*;

    localparam int CAPTURE_MAX = 10 * `PIX_IMAGE_SIZE + 20;
    localparam int READOUT_MAX = 12 * `PIX_IMAGE_SIZE + 20;
    localparam int RUN_CYCLES  = 5 * CAPTURE_MAX + 5 * READOUT_MAX + 50;
    localparam int ACK_LIMIT   = 8;

    logic       clk;
    logic       rst_n;
    logic       cmd_req;
    ctrl_cmd_t  cmd;
    logic       cmd_ack;
    pix_bus_t   pix;
    logic       rd_req;
    logic       rd_ack;
    pix_word_t  rd_data;

    int         errors;
    int         checks;
    int         seed = 32'h2296bbb9;
    // Expected contents of every block, filled as pixels are admitted
    pix_word_t  ref_mem [`PIX_BLOCK_COUNT][`PIX_IMAGE_SIZE];

    tb_clk_gen u_clk_gen (
        .clk  (clk),
        .rst_n(rst_n)
    );

    pix_capture_top dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .cmd_req(cmd_req),
        .cmd    (cmd),
        .cmd_ack(cmd_ack),
        .pix    (pix),
        .rd_req (rd_req),
        .rd_ack (rd_ack),
        .rd_data(rd_data)
    );

    // ============================================================
    // Helpers and checks
    // ============================================================

    // Outputs are sampled and inputs driven 1 ns after each rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_word(input string name, input pix_word_t exp, input pix_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic wait_cmd_ack(input string name);
        int n;
        n = 0;
        while (cmd_ack !== 1'b1 && n < ACK_LIMIT) begin
            next_cycle();
            n++;
        end
        if (cmd_ack !== 1'b1) begin
            errors++;
            $display("%s: cmd_ack did not rise after the last pixel", name);
        end
    endtask

    // Ack must hold while req is high, then fall one cycle after req drops
    task automatic release_cmd(input string name);
        check_bit({name, "/cmd_ack"}, 1'b1, cmd_ack);
        repeat (2) begin
            next_cycle();
            check_bit({name, "/cmd_ack held"}, 1'b1, cmd_ack);
        end
        cmd_req = 1'b0;
        next_cycle();
        check_bit({name, "/cmd_ack released"}, 1'b0, cmd_ack);
        next_cycle();
    endtask

    // Mode 0 clean stream, 1 fixed valid and lv holes, 2 random holes
    task automatic run_capture(input string name, input logic [`PIX_BLOCK_W-1:0] block,
                               input int mode);
        logic [31:0]              r;
        logic [`PIX_OFFSET_W-1:0] off;
        int                       admitted;
        int                       n;
        admitted = 0;
        n = 0;
        off = '0;
        cmd.op = OP_CAPTURE;
        cmd.block = block;
        cmd_req = 1'b1;
        // Frame already running, so none of these may be stored
        repeat (4) begin
            r = $random(seed);
            pix = '{valid: 1'b1, fv: 1'b1, lv: 1'b1, data: r[11:0]};
            next_cycle();
        end
        repeat (2) begin
            r = $random(seed);
            pix = '{valid: 1'b1, fv: 1'b0, lv: 1'b1, data: r[11:0]};
            next_cycle();
        end
        while (admitted < `PIX_IMAGE_SIZE) begin
            r = $random(seed);
            pix.fv = 1'b1;
            pix.data = r[11:0];
            case (mode)
                1: begin
                    pix.valid = (n % 3) != 2;
                    pix.lv = (n % 4) != 3;
                end
                2: begin
                    pix.valid = r[12];
                    pix.lv = r[13] | r[14];
                end
                default: begin
                    pix.valid = 1'b1;
                    pix.lv = 1'b1;
                end
            endcase
            // Frame has started here, so only the holes in valid and lv drop pixels
            if (pix.valid && pix.lv) begin
                ref_mem[block][off] = '{pad: 4'h0, pixel: pix.data};
                off = off + 1'b1;
                admitted++;
            end
            n++;
            next_cycle();
        end
        pix = '0;
        wait_cmd_ack(name);
        release_cmd(name);
    endtask

    // Hold keeps rd_req high after the ack, gap idles between words
    task automatic run_readout(input string name, input logic [`PIX_BLOCK_W-1:0] block,
                               input int hold, input int gap);
        logic [`PIX_OFFSET_W-1:0] off;
        off = '0;
        cmd.op = OP_READOUT;
        cmd.block = block;
        cmd_req = 1'b1;
        next_cycle();
        for (int i = 0; i < `PIX_IMAGE_SIZE; i++) begin
            rd_req = 1'b1;
            next_cycle();
            check_bit({name, "/rd_ack early"}, 1'b0, rd_ack);
            next_cycle();
            check_bit({name, "/rd_ack"}, 1'b1, rd_ack);
            check_word({name, "/rd_data"}, ref_mem[block][off], rd_data);
            repeat (hold) begin
                next_cycle();
                check_bit({name, "/rd_ack held"}, 1'b1, rd_ack);
                check_word({name, "/rd_data held"}, ref_mem[block][off], rd_data);
            end
            rd_req = 1'b0;
            next_cycle();
            check_bit({name, "/rd_ack released"}, 1'b0, rd_ack);
            next_cycle();
            repeat (gap) next_cycle();
            off = off + 1'b1;
        end
        release_cmd(name);
    endtask

    // ============================================================
    // Tests
    // ============================================================

    task automatic test_reset_state();
        check_bit("reset/cmd_ack", 1'b0, cmd_ack);
        check_bit("reset/rd_ack", 1'b0, rd_ack);
    endtask

    task automatic test_capture_readout();
        run_capture("capture_readout", 3'd0, 0);
        run_readout("capture_readout", 3'd0, 0, 0);
    endtask

    task automatic test_gating();
        run_capture("gating", 3'd1, 1);
        run_readout("gating", 3'd1, 0, 0);
    endtask

    task automatic test_block_isolation();
        run_capture("block_isolation", 3'd2, 0);
        run_capture("block_isolation", 3'd5, 1);
        run_readout("block_isolation", 3'd2, 0, 0);
        run_readout("block_isolation", 3'd5, 0, 1);
    endtask

    task automatic test_slow_host();
        run_capture("slow_host", 3'd7, 2);
        run_readout("slow_host", 3'd7, 3, 2);
    endtask

    initial begin
        cmd_req = 1'b0;
        cmd = '0;
        pix = '0;
        rd_req = 1'b0;
        errors = 0;
        checks = 0;
        wait (rst_n === 1'b1);
        next_cycle();
        test_reset_state();
        test_capture_readout();
        test_gating();
        test_block_isolation();
        test_slow_host();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Bound on the whole run, from the worst case length of each test
    initial begin
        #(RUN_CYCLES * 100);
        $display("Run timed out after %0d cycles, errors so far: %0d", RUN_CYCLES, errors);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: src.f
+incdir+source
source/pix_types_pkg.sv
source/ctrl_types_pkg.sv
source/pix_ctrl_fsm.sv
source/word_counter.sv
source/frame_gate.sv
source/frame_store.sv
source/readout_port.sv
source/pix_capture_top.sv
tb/tb_clk_gen.sv
tb/tb_pix_capture.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pix_capture
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
